//--- dv/edpClockGen.sv
/* Clock and reset for the data path testbench. Reset is released by the
   rising edge that ends the last reset cycle. */
`default_nettype none

module edpClockGen #(
  parameter int periodNs    = 20,
  parameter int resetCycles = 16
) (
  output logic eboxClk,
  output logic rstN
);

  timeunit 1ns;
  timeprecision 100ps;

  initial begin
    eboxClk = 1'b0;
    forever #(periodNs / 2) eboxClk = ~eboxClk;
  end

  initial begin
    rstN = 1'b0;
    repeat (resetCycles) @(posedge eboxClk);
    rstN <= 1'b1;
  end

endmodule

`default_nettype wire

//--- dv/edpTb.sv
/* Random microword testbench. The first 2**(4+fmBits) cycles write every
   fast-memory word in full, and until then the B path and EBUS avoid FM. */
`default_nettype none

module edpTb import edpPkg::*; ();

  timeunit 1ns;
  timeprecision 100ps;

  localparam int clkPeriod = 20;
  localparam int resetCycles = 16;
  localparam int numTests = 3000;
  localparam int fmBits = 1;
  localparam int fmDepth = 1 << (fmBits + 4);

  logic eboxClk;
  logic rstN;
  microWord ctrl = '0;
  logic [0:fmBits-1] fmBlock = '0;
  pdpWord cacheDataRead = '0;
  pdpWord ebusIn = '0;
  pdpWord shiftData = '0;
  pdpWord ad, ar, arx, br, brx, mq, fm, ebusOut;
  logic adCarry, fmParity, ebusDriving;

  // Reference state
  pdpWord mAr = '0;
  pdpWord mArx = '0;
  pdpWord mBr = '0;
  pdpWord mBrx = '0;
  pdpWord mMq = '0;
  pdpWord mEbus = '0;
  logic mDriving = 1'b0;
  pdpWord mFm [fmDepth];
  logic [fmDepth-1:0] mWritten = '0;

  logic [31:0] seed = 32'h616b;
  int driveCount = 0;
  int stepCount = 0;
  int checkCount = 0;
  int errorCount = 0;

  edpClockGen #(.periodNs(clkPeriod), .resetCycles(resetCycles)) uClockGen (
    .eboxClk(eboxClk),
    .rstN(rstN)
  );

  edp #(.fmBlockBits(fmBits)) UUT (
    .eboxClk(eboxClk), .rstN(rstN), .ctrl(ctrl), .fmBlock(fmBlock),
    .cacheDataRead(cacheDataRead), .ebusIn(ebusIn), .shiftData(shiftData),
    .ad(ad), .adCarry(adCarry), .ar(ar), .arx(arx), .br(br), .brx(brx),
    .mq(mq), .fm(fm), .fmParity(fmParity), .ebusOut(ebusOut),
    .ebusDriving(ebusDriving)
  );

  function automatic logic [31:0] lcg(input logic [31:0] s);
    return s * 32'd1664525 + 32'd1013904223;
  endfunction

  // Two draws give one 36-bit word from the upper bits
  task automatic nextWord(output pdpWord w);
    logic [31:0] hi;
    seed = lcg(seed);
    hi = seed;
    seed = lcg(seed);
    w = {hi[31:14], seed[31:14]};
  endtask

  task automatic compareValue(input string name, input pdpWord expected, input pdpWord actual);
    checkCount++;
    if (expected !== actual) begin
      errorCount++;
      $display("FAILED %s at step %0d: expected %h, actual %h",
               name, stepCount, expected, actual);
    end
  endtask

  // Expected AD from the adder function rules and the model's operands
  function automatic void refAd(input microWord c, input logic [0:fmBits-1] blk,
                                output pdpWord sum, output logic carry);
    pdpWord a;
    pdpWord b;
    logic [36:0] r;
    case (c.adaSel)
      adaAr:   a = mAr;
      adaArx:  a = mArx;
      adaMq:   a = mMq;
      default: a = '0;
    endcase
    case (c.adbSel)
      adbFm:      b = mFm[{blk, c.fmAdr}];
      adbBr:      b = mBr;
      adbBrShift: b = {mBr[1:35], mBrx[0]};
      default:    b = mArx;
    endcase
    r = '0;
    carry = 1'b0;
    case (c.adFn)
      adAdd: begin
        r = {1'b0, a} + {1'b0, b} + {36'd0, c.carryIn};
        carry = r[36];
      end
      adSub: begin
        // Negative result wraps into bit 36, which means a borrow
        r = {1'b0, a} - {1'b0, b} - 37'd1 + {36'd0, c.carryIn};
        carry = ~r[36];
      end
      adPassA: r[35:0] = a;
      adPassB: r[35:0] = b;
      adAnd:   r[35:0] = a & b;
      adOr:    r[35:0] = a | b;
      adXor:   r[35:0] = a ^ b;
      default: r[35:0] = ~a;
    endcase
    sum = r[35:0];
  endfunction

  // Advance the model by one microword, all sources taken before any update
  function automatic void refStep(input microWord c, input logic [0:fmBits-1] blk,
                                  input pdpWord cache, input pdpWord ebin, input pdpWord shd);
    pdpWord sum;
    pdpWord src;
    logic carry;
    logic [fmBits+3:0] adr;
    adr = {blk, c.fmAdr};
    refAd(c, blk, sum, carry);
    case (c.ebusSel)
      ebusAr:  src = mAr;
      ebusBr:  src = mBr;
      ebusMq:  src = mMq;
      ebusFm:  src = mFm[adr];
      ebusBrx: src = mBrx;
      ebusArx: src = mArx;
      ebusAd:  src = sum;
      default: src = '0;
    endcase
    if (c.fmWriteLeft) mFm[adr][0:17] = mAr[0:17];
    if (c.fmWriteRight) mFm[adr][18:35] = mAr[18:35];
    if (c.fmWriteLeft && c.fmWriteRight) mWritten[adr] = 1'b1;
    if (c.ebusDriveLeft) mEbus[0:17] = src[0:17];
    if (c.ebusDriveRight) mEbus[18:35] = src[18:35];
    mDriving = c.ebusDriveLeft | c.ebusDriveRight;
    if (c.brLoad) mBr = mAr;
    if (c.brxLoad) mBrx = mArx;
    case (c.mqFn)
      mqHold:  mMq = mMq;
      mqLoad:  mMq = sum;
      mqShl:   mMq = {mMq[1:35], carry};
      default: mMq = {mMq[0], mMq[0:34]};
    endcase
    if (c.arLoad) begin
      case (c.arSel)
        arAd:    mAr = sum;
        arCache: mAr = cache;
        arEbus:  mAr = ebin;
        default: mAr = shd;
      endcase
    end
    if (c.arxLoad) mArx = c.arxFromCache ? cache : sum;
  endfunction

  always @(posedge eboxClk) begin : driveStimulus
    microWord c;
    pdpWord w;
    logic [0:fmBits-1] blk;
    if (rstN) begin
      nextWord(w);
      c = microWord'(w[8:35]);
      blk = w[0:fmBits-1];
      // Fill phase writes one full word per cycle
      if (driveCount < fmDepth) begin
        {blk, c.fmAdr} = driveCount[fmBits+3:0];
        c.fmWriteLeft = 1'b1;
        c.fmWriteRight = 1'b1;
        if (c.adbSel == adbFm) c.adbSel = adbBr;
        if (c.ebusSel == ebusFm) c.ebusSel = ebusAr;
      end
      driveCount++;
      ctrl <= c;
      fmBlock <= blk;
      nextWord(w);
      cacheDataRead <= w;
      nextWord(w);
      ebusIn <= w;
      nextWord(w);
      shiftData <= w;
    end else begin
      c = '0;
      c.adbSel = adbBr;
      ctrl <= c;
    end
  end

  // Sample one time unit before the rising edge
  always @(negedge eboxClk) begin : compareOutputs
    pdpWord expAd;
    logic expCarry;
    logic [fmBits+3:0] adr;
    #(clkPeriod / 2 - 1);
    adr = {fmBlock, ctrl.fmAdr};
    compareValue("AR", mAr, ar);
    compareValue("ARX", mArx, arx);
    compareValue("BR", mBr, br);
    compareValue("BRX", mBrx, brx);
    compareValue("MQ", mMq, mq);
    compareValue("EBUS out", mEbus, ebusOut);
    compareValue("EBUS driving", 36'(mDriving), 36'(ebusDriving));
    if (rstN) begin
      refAd(ctrl, fmBlock, expAd, expCarry);
      compareValue("AD", expAd, ad);
      compareValue("AD carry", 36'(expCarry), 36'(adCarry));
      if (mWritten[adr]) begin
        compareValue("FM read", mFm[adr], fm);
        compareValue("FM parity", 36'(^mFm[adr]), 36'(fmParity));
      end
      refStep(ctrl, fmBlock, cacheDataRead, ebusIn, shiftData);
      stepCount++;
    end
  end

  initial begin
    wait (stepCount == numTests);
    $display("Checks: %0d, errors: %0d", checkCount, errorCount);
    if (errorCount == 0) begin
      $display("Testbench passed");
    end else begin
      $display("Testbench failed");
    end
    $finish;
  end

  initial begin
    #((resetCycles + numTests + 100) * clkPeriod);
    $display("Watchdog timeout, the test did not complete %0d steps", numTests);
    $display("Testbench failed");
    $finish;
  end

endmodule

`default_nettype wire

//--- runSim.sh
#!/bin/sh
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert -f vlog.f --top-module edpTb -o edpSim
./obj_dir/edpSim > sim.log 2>&1
cat sim.log

if grep -q "Testbench failed" sim.log; then
  exit 1
fi
exit 0

//--- src/adder36.sv
/* 36-bit AD adder, nine slices under two levels of look-ahead. cout is the
   carry out of bit 0 and reads zero for every logic function. */
`default_nettype none

module adder36 import edpPkg::*; (
  input  wire adFunc  fn,
  input  wire pdpWord a,
  input  wire pdpWord b,
  input  wire         cin,
  output pdpWord      sum,
  output logic        cout
);

  logic [0:8] sliceGen;
  logic [0:8] sliceProp;
  logic [0:8] sliceCin;
  logic [0:2] blockGen;
  logic [0:2] blockProp;
  logic [0:3] topCarries;

  // Slice 0 holds bits 0..3, slice 8 holds bits 32..35
  for (genvar s = 0; s < 9; s++) begin : gSlice
    aluSlice uSlice (
      .fn(fn),
      .a(a[4*s +: 4]),
      .b(b[4*s +: 4]),
      .cin(sliceCin[s]),
      .f(sum[4*s +: 4]),
      .groupGen(sliceGen[s]),
      .groupProp(sliceProp[s])
    );
  end

  // Three slices per lower unit in groups 1..3
  for (genvar k = 0; k < 3; k++) begin : gBlock
    logic [0:3] carries;
    // Top group passes the slice terms straight through
    carryLookahead uLower (
      .gen({1'b0, sliceGen[3*k +: 3]}),
      .prop({1'b1, sliceProp[3*k +: 3]}),
      .cin(topCarries[k+1]),
      .carries(carries),
      .blockGen(blockGen[k]),
      .blockProp(blockProp[k])
    );
    assign sliceCin[3*k +: 3] = carries[1:3];
  end

  // Upper unit, carry into its idle group 0 is the carry out of bit 0
  carryLookahead uUpper (
    .gen({1'b0, blockGen}),
    .prop({1'b0, blockProp}),
    .cin(cin),
    .carries(topCarries),
    .blockGen(),
    .blockProp()
  );

  assign cout = ((fn == adAdd) || (fn == adSub)) ? topCarries[0] : 1'b0;

endmodule

`default_nettype wire

//--- src/aluSlice.sv
/* 4-bit function slice in the style of a 10181. Generate and propagate are
   zero for the logic functions, so look-ahead carries only affect arithmetic. */
`default_nettype none

module aluSlice import edpPkg::*; (
  input  wire adFunc fn,
  input  wire nibble a,
  input  wire nibble b,
  input  wire        cin,
  output nibble      f,
  output logic       groupGen,
  output logic       groupProp
);

  nibble bx;
  nibble gBit;
  nibble pBit;
  nibble sum;
  logic  arith;

  assign arith = (fn == adAdd) || (fn == adSub);

  // Subtract is A plus not B plus carry-in
  assign bx = (fn == adSub) ? ~b : b;
  assign gBit = a & bx;
  assign pBit = a | bx;

  // Ripple within the slice, bit 3 is the least significant
  always_comb begin
    logic c;
    c = cin;
    for (int i = 3; i >= 0; i--) begin
      sum[i] = a[i] ^ bx[i] ^ c;
      c = gBit[i] | (pBit[i] & c);
    end
  end

  assign groupGen = arith & (gBit[0]
                             | (pBit[0] & gBit[1])
                             | (pBit[0] & pBit[1] & gBit[2])
                             | (pBit[0] & pBit[1] & pBit[2] & gBit[3]));
  assign groupProp = arith & (&pBit);

  always_comb begin
    case (fn)
      adAdd,
      adSub:   f = sum;
      adPassA: f = a;
      adPassB: f = b;
      adAnd:   f = a & b;
      adOr:    f = a | b;
      adXor:   f = a ^ b;
      adNotA:  f = ~a;
      default: f = '0;
    endcase
  end

  // Function select must never float while the slice is in use
  fnKnown: assert property (@(fn) !$isunknown(fn))
    else $error("aluSlice function select is unknown");

endmodule

`default_nettype wire

//--- src/carryLookahead.sv
/* Four-group carry look-ahead in the style of a 10179. Group 0 is the most
   significant; cin enters group 3. */
`default_nettype none

module carryLookahead (
  input  wire [0:3]  gen,
  input  wire [0:3]  prop,
  input  wire        cin,
  output logic [0:3] carries,
  output logic       blockGen,
  output logic       blockProp
);

  // Carry into each group
  assign carries[3] = cin;
  assign carries[2] = gen[3] | (prop[3] & cin);
  assign carries[1] = gen[2]
                      | (prop[2] & gen[3])
                      | (prop[2] & prop[3] & cin);
  assign carries[0] = gen[1]
                      | (prop[1] & gen[2])
                      | (prop[1] & prop[2] & gen[3])
                      | (prop[1] & prop[2] & prop[3] & cin);

  // Block terms for the next look-ahead level
  assign blockGen = gen[0]
                    | (prop[0] & gen[1])
                    | (prop[0] & prop[1] & gen[2])
                    | (prop[0] & prop[1] & prop[2] & gen[3]);
  assign blockProp = &prop;

endmodule

`default_nettype wire

//--- src/edp.sv
/* Reduced EBOX data path. One microword executes every cycle; AD and FM are
   combinational, registers and the EBUS output load at the closing edge. */
`default_nettype none

module edp import edpPkg::*; #(
  parameter int fmBlockBits = 1
) (
  input  wire                   eboxClk,
  input  wire                   rstN,
  input  wire microWord         ctrl,
  input  wire [0:fmBlockBits-1] fmBlock,
  input  wire pdpWord           cacheDataRead,
  input  wire pdpWord           ebusIn,
  input  wire pdpWord           shiftData,
  output pdpWord                ad,
  output logic                  adCarry,
  output pdpWord                ar,
  output pdpWord                arx,
  output pdpWord                br,
  output pdpWord                brx,
  output pdpWord                mq,
  output pdpWord                fm,
  output logic                  fmParity,
  output pdpWord                ebusOut,
  output logic                  ebusDriving
);

  pdpWord ada;
  pdpWord adb;
  pdpWord arNext;
  pdpWord arxNext;
  pdpWord mqNext;
  pdpWord ebusSrc;

  // A operand
  always_comb begin
    case (ctrl.adaSel)
      adaAr:   ada = ar;
      adaArx:  ada = arx;
      adaMq:   ada = mq;
      default: ada = '0;
    endcase
  end

  // B operand, the shifted BR picks up BRX bit 0
  always_comb begin
    case (ctrl.adbSel)
      adbFm:      adb = fm;
      adbBr:      adb = br;
      adbBrShift: adb = {br[1:35], brx[0]};
      default:    adb = arx;
    endcase
  end

  adder36 uAdder (
    .fn(ctrl.adFn),
    .a(ada),
    .b(adb),
    .cin(ctrl.carryIn),
    .sum(ad),
    .cout(adCarry)
  );

  fastMem #(
    .fmBlockBits(fmBlockBits)
  ) uFastMem (
    .eboxClk(eboxClk),
    .adr({fmBlock, ctrl.fmAdr}),
    .wdata(ar),
    .writeLeft(ctrl.fmWriteLeft),
    .writeRight(ctrl.fmWriteRight),
    .rdata(fm)
  );

  assign fmParity = ^fm;

  always_comb begin
    case (ctrl.arSel)
      arAd:    arNext = ad;
      arCache: arNext = cacheDataRead;
      arEbus:  arNext = ebusIn;
      default: arNext = shiftData;
    endcase
  end

  assign arxNext = ctrl.arxFromCache ? cacheDataRead : ad;

  // MQ shifter, left shift takes the adder carry into bit 35
  always_comb begin
    case (ctrl.mqFn)
      mqHold:  mqNext = mq;
      mqLoad:  mqNext = ad;
      mqShl:   mqNext = {mq[1:35], adCarry};
      default: mqNext = {mq[0], mq[0:34]};
    endcase
  end

  // BR and BRX see the values AR and ARX held before this edge
  always_ff @(posedge eboxClk or negedge rstN) begin
    if (!rstN) begin
      ar  <= '0;
      arx <= '0;
      br  <= '0;
      brx <= '0;
      mq  <= '0;
    end else begin
      if (ctrl.arLoad) begin
        ar <= arNext;
      end
      if (ctrl.arxLoad) begin
        arx <= arxNext;
      end
      if (ctrl.brLoad) begin
        br <= ar;
      end
      if (ctrl.brxLoad) begin
        brx <= arx;
      end
      mq <= mqNext;
    end
  end

  // EBUS source
  always_comb begin
    case (ctrl.ebusSel)
      ebusAr:  ebusSrc = ar;
      ebusBr:  ebusSrc = br;
      ebusMq:  ebusSrc = mq;
      ebusFm:  ebusSrc = fm;
      ebusBrx: ebusSrc = brx;
      ebusArx: ebusSrc = arx;
      ebusAd:  ebusSrc = ad;
      default: ebusSrc = '0;
    endcase
  end

  // Undriven half keeps its last value
  always_ff @(posedge eboxClk or negedge rstN) begin
    if (!rstN) begin
      ebusOut     <= '0;
      ebusDriving <= 1'b0;
    end else begin
      if (ctrl.ebusDriveLeft) begin
        ebusOut[0:17] <= ebusSrc[0:17];
      end
      if (ctrl.ebusDriveRight) begin
        ebusOut[18:35] <= ebusSrc[18:35];
      end
      ebusDriving <= ctrl.ebusDriveLeft | ctrl.ebusDriveRight;
    end
  end

  // Anything put on the bus must be a real value
  ebusKnown: assert property (
    @(posedge eboxClk) disable iff (!rstN) ebusDriving |-> !$isunknown(ebusOut)
  ) else $error("EBUS driven with unknown data");

endmodule

`default_nettype wire

//--- src/edpPkg.sv
/* Shared types for the 36-bit data path. Bit 0 is the most significant bit.
   The microword is a plain per-cycle control word with no handshake. */
`default_nettype none

package edpPkg;

  // Data words use PDP-10 bit numbering
  typedef logic [0:35] pdpWord;
  typedef logic [0:3] nibble;
  typedef logic [0:3] fmAddr;

  // Adder functions, carry-out only defined for add and subtract
  typedef enum logic [2:0] {
    adAdd   = 3'd0,
    adSub   = 3'd1,
    adPassA = 3'd2,
    adPassB = 3'd3,
    adAnd   = 3'd4,
    adOr    = 3'd5,
    adXor   = 3'd6,
    adNotA  = 3'd7
  } adFunc;

  typedef enum logic [1:0] {
    adaAr   = 2'd0,
    adaArx  = 2'd1,
    adaMq   = 2'd2,
    adaZero = 2'd3
  } adaSelect;

  // BR shifted left takes BRX bit 0 into bit 35
  typedef enum logic [1:0] {
    adbFm      = 2'd0,
    adbBr      = 2'd1,
    adbBrShift = 2'd2,
    adbArx     = 2'd3
  } adbSelect;

  typedef enum logic [1:0] {
    arAd    = 2'd0,
    arCache = 2'd1,
    arEbus  = 2'd2,
    arShift = 2'd3
  } arSelect;

  typedef enum logic [1:0] {
    mqHold = 2'd0,
    mqLoad = 2'd1,
    mqShl  = 2'd2,
    mqAsr  = 2'd3
  } mqFunc;

  typedef enum logic [2:0] {
    ebusAr   = 3'd0,
    ebusBr   = 3'd1,
    ebusMq   = 3'd2,
    ebusFm   = 3'd3,
    ebusBrx  = 3'd4,
    ebusArx  = 3'd5,
    ebusAd   = 3'd6,
    ebusZero = 3'd7
  } ebusSelect;

  // One microword per eboxClk cycle, 28 bits
  typedef struct packed {
    adFunc     adFn;
    adaSelect  adaSel;
    adbSelect  adbSel;
    logic      carryIn;
    arSelect   arSel;
    logic      arLoad;
    logic      arxFromCache;
    logic      arxLoad;
    logic      brLoad;
    logic      brxLoad;
    mqFunc     mqFn;
    fmAddr     fmAdr;
    logic      fmWriteLeft;
    logic      fmWriteRight;
    ebusSelect ebusSel;
    logic      ebusDriveLeft;
    logic      ebusDriveRight;
  } microWord;

endpackage

`default_nettype wire

//--- src/fastMem.sv
/* Fast-memory accumulator file, 2**(4+fmBlockBits) words. Read is
   combinational; contents are undefined until written. */
`default_nettype none

module fastMem import edpPkg::*; #(
  parameter int fmBlockBits = 1
) (
  input  wire                       eboxClk,
  input  wire [0:fmBlockBits+3]     adr,
  input  wire pdpWord               wdata,
  input  wire                       writeLeft,
  input  wire                       writeRight,
  output pdpWord                    rdata
);

  localparam int depth = 1 << (fmBlockBits + 4);

  pdpWord mem [depth];

  // Halfword writes land independently
  always_ff @(posedge eboxClk) begin
    if (writeLeft) begin
      mem[adr][0:17] <= wdata[0:17];
    end
    if (writeRight) begin
      mem[adr][18:35] <= wdata[18:35];
    end
  end

  assign rdata = mem[adr];

  // A write to an unknown address would corrupt an arbitrary accumulator
  writeAdrKnown: assert property (
    @(posedge eboxClk) (writeLeft || writeRight) |-> !$isunknown(adr)
  ) else $error("fastMem write with unknown address");

endmodule

`default_nettype wire

//--- vlog.f
src/edpPkg.sv
src/aluSlice.sv
src/carryLookahead.sv
src/adder36.sv
src/fastMem.sv
src/edp.sv
dv/edpClockGen.sv
dv/edpTb.sv
